// ==== hdl/miss_pkg.sv ====
/*
  Shared definitions for the cache miss handler.
  Holds the cache geometry, the derived field widths and the enums for
  request opcodes, DMA commands and metadata write kinds.
  Modules pull these in with a wildcard import in their header.
*/
package miss_pkg;

  // the cache is 4-way set associative with 16 sets of 16-byte blocks.
  localparam int ADDR_WIDTH = 16;
  localparam int WAYS = 4;
  localparam int LG_WAYS = $clog2(WAYS);
  localparam int SETS = 16;
  localparam int LG_SETS = $clog2(SETS);
  localparam int BLOCK_OFFSET_WIDTH = 4;

  // the tag is whatever remains of the address above the index.
  localparam int TAG_WIDTH = ADDR_WIDTH - LG_SETS - BLOCK_OFFSET_WIDTH;

  // a pseudo-LRU tree over the ways has one bit per inner node.
  localparam int LRU_WIDTH = WAYS - 1;

  // operations that can reach the miss handler.
  typedef enum logic [2:0] {
    e_op_load   = 3'd0,
    e_op_store  = 3'd1,
    e_op_afl    = 3'd2,
    e_op_ainv   = 3'd3,
    e_op_aflinv = 3'd4
  } miss_op_e;

  // commands issued to the DMA engine.
  typedef enum logic [2:0] {
    e_dma_nop             = 3'd0,
    e_dma_send_fill_addr  = 3'd1,
    e_dma_send_evict_addr = 3'd2,
    e_dma_send_evict_data = 3'd3,
    e_dma_get_fill_data   = 3'd4
  } dma_cmd_e;

  // kind of metadata update requested by the FSM in a given cycle.
  typedef enum logic [1:0] {
    e_meta_none  = 2'd0,
    e_meta_fill  = 2'd1,
    e_meta_flush = 2'd2
  } meta_write_e;

endpackage

// ==== hdl/miss_req_if.sv ====
/*
  Captured miss request as seen by the processing side of the handler.
  The intake drives the request and the set snapshot, the FSM answers
  with a one-cycle release, and other blocks only look at the contents.
*/
interface miss_req_if
  import miss_pkg::*;
();

  logic                               req_valid;
  miss_op_e                           op;
  logic [TAG_WIDTH-1:0]               tag;
  logic [LG_SETS-1:0]                 index;
  logic [WAYS-1:0][TAG_WIDTH-1:0]     tags;
  logic [WAYS-1:0]                    valid;
  logic [WAYS-1:0]                    dirty;
  logic [LRU_WIDTH-1:0]               lru_bits;
  logic [WAYS-1:0]                    hit;
  logic [LG_WAYS-1:0]                 hit_way;
  logic                               release_req;

  modport intake (
    output req_valid, op, tag, index, tags, valid, dirty, lru_bits, hit, hit_way,
    input  release_req
  );

  modport fsm (
    input  req_valid, op, tag, index, tags, valid, dirty, hit, hit_way,
    output release_req
  );

  modport view (
    input req_valid, op, tag, index, tags, valid, dirty, lru_bits, hit, hit_way
  );

endinterface

// ==== hdl/miss_intake.sv ====
/*
  Input side of the miss handler.
  Registers a missing request together with the metadata of its set,
  splits the address and encodes the hit way, then holds all of it
  stable until the FSM releases the request.
*/
module miss_intake
  import miss_pkg::*;
(
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic                           miss_v_i,
  input  miss_op_e                       op_i,
  input  logic [ADDR_WIDTH-1:0]          addr_i,
  input  logic [WAYS-1:0][TAG_WIDTH-1:0] tags_i,
  input  logic [WAYS-1:0]                valid_i,
  input  logic [WAYS-1:0]                dirty_i,
  input  logic [LRU_WIDTH-1:0]           lru_bits_i,
  input  logic [WAYS-1:0]                tag_hit_i,
  miss_req_if.intake                     req_o
);

  logic               capture;
  logic [LG_WAYS-1:0] hit_way_enc;

  // a new request is only taken while nothing is held.
  assign capture = miss_v_i & ~req_o.req_valid;

  // lowest set bit of the hit vector wins.
  always_comb begin
    hit_way_enc = '0;
    for (int w = WAYS - 1; w >= 0; w--) begin
      if (tag_hit_i[w]) begin
        hit_way_enc = LG_WAYS'(w);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      req_o.req_valid <= 1'b0;
    end else if (capture) begin
      req_o.req_valid <= 1'b1;
    end else if (req_o.release_req) begin
      req_o.req_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture) begin
      req_o.op       <= op_i;
      req_o.tag      <= addr_i[BLOCK_OFFSET_WIDTH+LG_SETS +: TAG_WIDTH];
      req_o.index    <= addr_i[BLOCK_OFFSET_WIDTH +: LG_SETS];
      req_o.tags     <= tags_i;
      req_o.valid    <= valid_i;
      req_o.dirty    <= dirty_i;
      req_o.lru_bits <= lru_bits_i;
      req_o.hit      <= tag_hit_i;
      req_o.hit_way  <= hit_way_enc;
    end
  end

  // the lookup stage must never report a tag in two ways of one set.
  a_hit_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    capture |-> $onehot0(tag_hit_i))
    else $error("miss_intake: more than one tag hit in a captured request");

endmodule

// ==== hdl/victim_select.sv ====
/*
  Replacement way selection for a fill.
  An invalid way is taken first, lowest number first. With every way
  valid, the pseudo-LRU tree of the set is walked down to its LRU leaf.
  Purely combinational.
*/
module victim_select
  import miss_pkg::*;
(
  miss_req_if.view           req_i,
  output logic [LG_WAYS-1:0] victim_way_o
);

  logic [LG_WAYS-1:0] invalid_way;
  logic               invalid_found;
  logic [LG_WAYS-1:0] lru_way;

  // scan from the top so that the lowest invalid way is the last written.
  always_comb begin
    invalid_way   = '0;
    invalid_found = 1'b0;
    for (int w = WAYS - 1; w >= 0; w--) begin
      if (!req_i.valid[w]) begin
        invalid_way   = LG_WAYS'(w);
        invalid_found = 1'b1;
      end
    end
  end

  // node 0 is the root and node n has children 2n+1 and 2n+2.
  // A zero bit sends the walk to the lower-numbered half, so each
  // visited bit also becomes the next way bit, msb first.
  always_comb begin
    int node;
    node    = 0;
    lru_way = '0;
    for (int level = 0; level < LG_WAYS; level++) begin
      lru_way[LG_WAYS-1-level] = req_i.lru_bits[node];
      node = 2 * node + 1 + int'(req_i.lru_bits[node]);
    end
  end

  assign victim_way_o = invalid_found ? invalid_way : lru_way;

endmodule

// ==== hdl/miss_fsm.sv ====
/*
  Miss handler state machine.
  Loads and stores send the fill address, evict a dirty victim when
  needed and fetch the fill data. Flush operations act on the hit way
  and evict only dirty lines. Each request ends with a recover pulse
  followed by done, which is held until the pipeline acknowledges.
*/
module miss_fsm
  import miss_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,
  miss_req_if.fsm               req_i,
  input  logic [LG_WAYS-1:0]    victim_way_i,
  output dma_cmd_e              dma_cmd_o,
  output logic [ADDR_WIDTH-1:0] dma_addr_o,
  output logic [LG_WAYS-1:0]    dma_way_o,
  input  logic                  dma_done_i,
  output meta_write_e           meta_write_o,
  output logic [LG_WAYS-1:0]    chosen_way_o,
  output logic                  recover_o,
  output logic                  done_o,
  input  logic                  ack_i
);

  typedef enum logic [2:0] {
    START,
    FLUSH_OP,
    SEND_FILL_ADDR,
    SEND_EVICT_ADDR,
    SEND_EVICT_DATA,
    GET_FILL_DATA,
    RECOVER,
    DONE
  } state_e;

  state_e               state_r;
  state_e               state_n;
  logic [LG_WAYS-1:0]   chosen_way_r;
  logic [LG_WAYS-1:0]   chosen_way_n;
  logic                 is_fill_op;
  logic                 victim_needs_evict;
  logic                 hit_needs_evict;
  logic                 in_dma_state;
  logic [TAG_WIDTH-1:0] evict_tag;

  assign is_fill_op = (req_i.op == e_op_load) || (req_i.op == e_op_store);

  // a line goes back to memory only when it is both valid and dirty.
  assign victim_needs_evict = req_i.valid[victim_way_i] & req_i.dirty[victim_way_i];
  assign hit_needs_evict = (req_i.op != e_op_ainv) & (|req_i.hit)
                         & req_i.valid[req_i.hit_way] & req_i.dirty[req_i.hit_way];

  // the victim is not latched until the fill address is accepted, so it is
  // taken straight from the selector while the command is pending.
  always_comb begin
    if (!is_fill_op) begin
      dma_way_o = req_i.hit_way;
    end else if (state_r == SEND_FILL_ADDR) begin
      dma_way_o = victim_way_i;
    end else begin
      dma_way_o = chosen_way_r;
    end
  end

  assign evict_tag    = req_i.tags[dma_way_o];
  assign chosen_way_o = chosen_way_r;
  assign recover_o    = (state_r == RECOVER);
  assign done_o       = (state_r == DONE);
  assign req_i.release_req = (state_r == DONE) & ack_i;

  always_comb begin
    state_n      = state_r;
    chosen_way_n = chosen_way_r;
    dma_cmd_o    = e_dma_nop;
    dma_addr_o   = '0;
    meta_write_o = e_meta_none;
    case (state_r)
      START: begin
        if (req_i.req_valid) begin
          state_n = is_fill_op ? SEND_FILL_ADDR : FLUSH_OP;
        end
      end
      FLUSH_OP: begin
        meta_write_o = e_meta_flush;
        state_n = hit_needs_evict ? SEND_EVICT_ADDR : RECOVER;
      end
      SEND_FILL_ADDR: begin
        chosen_way_n = victim_way_i;
        dma_cmd_o    = e_dma_send_fill_addr;
        dma_addr_o   = {req_i.tag, req_i.index, {BLOCK_OFFSET_WIDTH{1'b0}}};
        if (dma_done_i) begin
          state_n = victim_needs_evict ? SEND_EVICT_ADDR : GET_FILL_DATA;
        end
      end
      SEND_EVICT_ADDR: begin
        dma_cmd_o  = e_dma_send_evict_addr;
        dma_addr_o = {evict_tag, req_i.index, {BLOCK_OFFSET_WIDTH{1'b0}}};
        if (dma_done_i) begin
          state_n = SEND_EVICT_DATA;
        end
      end
      SEND_EVICT_DATA: begin
        dma_cmd_o  = e_dma_send_evict_data;
        dma_addr_o = {evict_tag, req_i.index, {BLOCK_OFFSET_WIDTH{1'b0}}};
        if (dma_done_i) begin
          state_n = is_fill_op ? GET_FILL_DATA : RECOVER;
        end
      end
      GET_FILL_DATA: begin
        dma_cmd_o  = e_dma_get_fill_data;
        dma_addr_o = {req_i.tag, req_i.index, {BLOCK_OFFSET_WIDTH{1'b0}}};
        if (dma_done_i) begin
          meta_write_o = e_meta_fill;
          state_n      = RECOVER;
        end
      end
      RECOVER: begin
        state_n = DONE;
      end
      DONE: begin
        if (ack_i) begin
          state_n = START;
        end
      end
      default: begin
        state_n = START;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r      <= START;
      chosen_way_r <= '0;
    end else begin
      state_r      <= state_n;
      chosen_way_r <= chosen_way_n;
    end
  end

  assign in_dma_state = state_r inside {SEND_FILL_ADDR, SEND_EVICT_ADDR,
                                        SEND_EVICT_DATA, GET_FILL_DATA};

  a_dma_cmd_active: assert property (@(posedge clk_i) disable iff (reset_i)
    in_dma_state |-> dma_cmd_o != e_dma_nop)
    else $error("miss_fsm: nop command issued in a DMA state");

  // a pending command must not move until the engine reports done, which
  // also depends on the intake keeping the request stable.
  a_dma_cmd_held: assert property (@(posedge clk_i) disable iff (reset_i)
    in_dma_state && !dma_done_i |=>
      $stable(dma_cmd_o) && $stable(dma_addr_o) && $stable(dma_way_o))
    else $error("miss_fsm: DMA command changed before dma_done_i");

endmodule

// ==== hdl/meta_write_gen.sv ====
/*
  Stat-memory and tag-memory write generation.
  Turns the FSM write request into data and masks for the set being
  handled. A fill installs the new tag and moves the LRU tree away
  from the chosen way, a flush clears dirty and optionally valid.
*/
module meta_write_gen
  import miss_pkg::*;
(
  miss_req_if.view              req_i,
  input  meta_write_e           meta_write_i,
  input  logic [LG_WAYS-1:0]    chosen_way_i,
  output logic                  stat_we_o,
  output logic [LG_SETS-1:0]    stat_index_o,
  output logic [WAYS-1:0]       stat_dirty_o,
  output logic [WAYS-1:0]       stat_dirty_mask_o,
  output logic [LRU_WIDTH-1:0]  stat_lru_o,
  output logic [LRU_WIDTH-1:0]  stat_lru_mask_o,
  output logic                  tag_we_o,
  output logic [LG_SETS-1:0]    tag_index_o,
  output logic [TAG_WIDTH-1:0]  tag_o,
  output logic                  tag_valid_o,
  output logic [WAYS-1:0]       tag_way_mask_o
);

  logic [WAYS-1:0]      chosen_onehot;
  logic [LRU_WIDTH-1:0] lru_data;
  logic [LRU_WIDTH-1:0] lru_mask;
  logic                 inv_op;

  assign chosen_onehot = WAYS'(1) << chosen_way_i;
  assign inv_op = (req_i.op == e_op_ainv) || (req_i.op == e_op_aflinv);

  // every node on the path to the chosen way is written so that it points
  // to the other subtree, which makes the new line the most recent one.
  always_comb begin
    int node;
    logic branch;
    node     = 0;
    lru_data = '0;
    lru_mask = '0;
    for (int level = 0; level < LG_WAYS; level++) begin
      branch         = chosen_way_i[LG_WAYS-1-level];
      lru_mask[node] = 1'b1;
      lru_data[node] = ~branch;
      node = 2 * node + 1 + int'(branch);
    end
  end

  assign stat_index_o = req_i.index;
  assign tag_index_o  = req_i.index;

  always_comb begin
    stat_we_o         = 1'b0;
    stat_dirty_o      = '0;
    stat_dirty_mask_o = '0;
    stat_lru_o        = '0;
    stat_lru_mask_o   = '0;
    tag_we_o          = 1'b0;
    tag_o             = '0;
    tag_valid_o       = 1'b0;
    tag_way_mask_o    = '0;
    case (meta_write_i)
      e_meta_fill: begin
        stat_we_o         = 1'b1;
        stat_dirty_o      = {WAYS{req_i.op == e_op_store}};
        stat_dirty_mask_o = chosen_onehot;
        stat_lru_o        = lru_data;
        stat_lru_mask_o   = lru_mask;
        tag_we_o          = 1'b1;
        tag_o             = req_i.tag;
        tag_valid_o       = 1'b1;
        tag_way_mask_o    = chosen_onehot;
      end
      e_meta_flush: begin
        // the hit vector is already the one-hot of the hit way.
        stat_we_o         = 1'b1;
        stat_dirty_mask_o = req_i.hit;
        tag_we_o          = inv_op;
        tag_way_mask_o    = inv_op ? req_i.hit : '0;
      end
      default: begin
      end
    endcase
  end

endmodule

// ==== hdl/miss_unit.sv ====
/*
  Top level of the cache miss handler.
  Connects the request intake, victim selection, the miss FSM and the
  metadata write generator around one captured request.
*/
module miss_unit
  import miss_pkg::*;
(
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic                           miss_v_i,
  input  miss_op_e                       op_i,
  input  logic [ADDR_WIDTH-1:0]          addr_i,
  input  logic [WAYS-1:0][TAG_WIDTH-1:0] tags_i,
  input  logic [WAYS-1:0]                valid_i,
  input  logic [WAYS-1:0]                dirty_i,
  input  logic [LRU_WIDTH-1:0]           lru_bits_i,
  input  logic [WAYS-1:0]                tag_hit_i,
  output dma_cmd_e                       dma_cmd_o,
  output logic [ADDR_WIDTH-1:0]          dma_addr_o,
  output logic [LG_WAYS-1:0]             dma_way_o,
  input  logic                           dma_done_i,
  output logic [LG_WAYS-1:0]             chosen_way_o,
  output logic                           recover_o,
  output logic                           done_o,
  input  logic                           ack_i,
  output logic                           stat_we_o,
  output logic [LG_SETS-1:0]             stat_index_o,
  output logic [WAYS-1:0]                stat_dirty_o,
  output logic [WAYS-1:0]                stat_dirty_mask_o,
  output logic [LRU_WIDTH-1:0]           stat_lru_o,
  output logic [LRU_WIDTH-1:0]           stat_lru_mask_o,
  output logic                           tag_we_o,
  output logic [LG_SETS-1:0]             tag_index_o,
  output logic [TAG_WIDTH-1:0]           tag_o,
  output logic                           tag_valid_o,
  output logic [WAYS-1:0]                tag_way_mask_o
);

  logic [LG_WAYS-1:0] victim_way;
  meta_write_e        meta_write;

  miss_req_if req_if ();

  miss_intake u_intake (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .miss_v_i   (miss_v_i),
    .op_i       (op_i),
    .addr_i     (addr_i),
    .tags_i     (tags_i),
    .valid_i    (valid_i),
    .dirty_i    (dirty_i),
    .lru_bits_i (lru_bits_i),
    .tag_hit_i  (tag_hit_i),
    .req_o      (req_if.intake)
  );

  victim_select u_victim (
    .req_i        (req_if.view),
    .victim_way_o (victim_way)
  );

  miss_fsm u_fsm (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .req_i        (req_if.fsm),
    .victim_way_i (victim_way),
    .dma_cmd_o    (dma_cmd_o),
    .dma_addr_o   (dma_addr_o),
    .dma_way_o    (dma_way_o),
    .dma_done_i   (dma_done_i),
    .meta_write_o (meta_write),
    .chosen_way_o (chosen_way_o),
    .recover_o    (recover_o),
    .done_o       (done_o),
    .ack_i        (ack_i)
  );

  meta_write_gen u_meta (
    .req_i             (req_if.view),
    .meta_write_i      (meta_write),
    .chosen_way_i      (chosen_way_o),
    .stat_we_o         (stat_we_o),
    .stat_index_o      (stat_index_o),
    .stat_dirty_o      (stat_dirty_o),
    .stat_dirty_mask_o (stat_dirty_mask_o),
    .stat_lru_o        (stat_lru_o),
    .stat_lru_mask_o   (stat_lru_mask_o),
    .tag_we_o          (tag_we_o),
    .tag_index_o       (tag_index_o),
    .tag_o             (tag_o),
    .tag_valid_o       (tag_valid_o),
    .tag_way_mask_o    (tag_way_mask_o)
  );

endmodule

// ==== testbench/miss_tb_checks.svh ====
/*
  Checks for the miss handler testbench, included into its top module.
  Reference functions give the victim and LRU update for four ways, and
  concurrent assertions compare the DUT against the expected request.
*/
`ifndef MISS_TB_CHECKS_SVH
`define MISS_TB_CHECKS_SVH

task automatic value_error(input string test, input logic [31:0] exp, input logic [31:0] act);
  $display("ERR %s: expected %0h, actual %0h", test, exp, act);
  $display("Result: FAILED");
  $fatal(1);
endtask

// lowest invalid way, else root bit picks the half and the child bit the way.
function automatic logic [1:0] ref_victim(input logic [3:0] valid, input logic [2:0] lru);
  if (!valid[0]) return 2'd0;
  if (!valid[1]) return 2'd1;
  if (!valid[2]) return 2'd2;
  if (!valid[3]) return 2'd3;
  if (!lru[0]) return {1'b0, lru[1]};
  return {1'b1, lru[2]};
endfunction

function automatic logic [2:0] ref_lru_mask(input logic [1:0] way);
  return way[1] ? 3'b101 : 3'b011;
endfunction

function automatic logic [2:0] ref_lru_data(input logic [1:0] way);
  return {way == 2'd2, way == 2'd0, ~way[1]};
endfunction

a_idle: assert property (@(posedge clk_i) disable iff (reset_i)
  !req_sent |-> dma_cmd_o == e_dma_nop && !stat_we_o && !tag_we_o && !recover_o && !done_o)
  else value_error("after_reset", 0, {dma_cmd_o, stat_we_o, tag_we_o, recover_o, done_o});

a_fill_addr: assert property (@(posedge clk_i) disable iff (reset_i)
  dma_cmd_o == e_dma_send_fill_addr |-> dma_addr_o == {exp_tag, exp_index, 4'h0})
  else value_error("fill_addr", {exp_tag, exp_index, 4'h0}, dma_addr_o);
a_evict_addr: assert property (@(posedge clk_i) disable iff (reset_i)
  dma_cmd_o == e_dma_send_evict_addr |-> dma_addr_o == {tags_i[exp_way], exp_index, 4'h0})
  else value_error("evict_addr", {tags_i[exp_way], exp_index, 4'h0}, dma_addr_o);
a_dma_way: assert property (@(posedge clk_i) disable iff (reset_i)
  dma_cmd_o != e_dma_nop |-> dma_way_o == exp_way)
  else value_error("dma_way", exp_way, dma_way_o);
a_evict_allowed: assert property (@(posedge clk_i) disable iff (reset_i)
  dma_cmd_o == e_dma_send_evict_addr |-> exp_evict)
  else value_error("unexpected_evict", 0, 1);
a_order_data: assert property (@(posedge clk_i) disable iff (reset_i)
  dma_cmd_o == e_dma_send_evict_data |-> last_cmd == e_dma_send_evict_addr)
  else value_error("evict_order", e_dma_send_evict_addr, last_cmd);
a_order_fill: assert property (@(posedge clk_i) disable iff (reset_i)
  dma_cmd_o == e_dma_get_fill_data
    |-> last_cmd == (exp_evict ? e_dma_send_evict_data : e_dma_send_fill_addr))
  else value_error("fill_order", exp_evict ? e_dma_send_evict_data : e_dma_send_fill_addr,
                   last_cmd);

a_meta_index: assert property (@(posedge clk_i) disable iff (reset_i)
  stat_we_o |-> stat_index_o == exp_index && tag_index_o == exp_index)
  else value_error("meta_index", {exp_index, exp_index}, {stat_index_o, tag_index_o});

a_fill_way: assert property (@(posedge clk_i) disable iff (reset_i)
  stat_we_o && exp_fill |-> chosen_way_o == exp_way)
  else value_error("fill_way", exp_way, chosen_way_o);
a_fill_tag: assert property (@(posedge clk_i) disable iff (reset_i)
  stat_we_o && exp_fill |-> tag_we_o && tag_o == exp_tag && tag_valid_o
    && tag_way_mask_o == 4'(1 << exp_way))
  else value_error("fill_tag", {1'b1, exp_tag}, {tag_valid_o, tag_o});
a_fill_dirty: assert property (@(posedge clk_i) disable iff (reset_i)
  stat_we_o && exp_fill |-> stat_dirty_mask_o == 4'(1 << exp_way)
    && stat_dirty_o[exp_way] == exp_store)
  else value_error("fill_dirty", exp_store, stat_dirty_o[exp_way]);
a_fill_lru: assert property (@(posedge clk_i) disable iff (reset_i)
  stat_we_o && exp_fill |-> stat_lru_mask_o == ref_lru_mask(exp_way)
    && (stat_lru_o & stat_lru_mask_o) == ref_lru_data(exp_way))
  else value_error("fill_lru", {ref_lru_mask(exp_way), ref_lru_data(exp_way)},
                   {stat_lru_mask_o, stat_lru_o & stat_lru_mask_o});
a_fill_timing: assert property (@(posedge clk_i) disable iff (reset_i)
  stat_we_o && exp_fill |-> dma_cmd_o == e_dma_get_fill_data && dma_done_i)
  else value_error("fill_write_cycle", e_dma_get_fill_data, dma_cmd_o);

// a flush clears dirty on the hit way and leaves the LRU tree alone.
a_flush_dirty: assert property (@(posedge clk_i) disable iff (reset_i)
  stat_we_o && !exp_fill |-> stat_dirty_mask_o == 4'(1 << exp_way) && stat_dirty_o == '0
    && stat_lru_mask_o == '0)
  else value_error("flush_dirty", {4'(1 << exp_way), 4'h0, 3'h0},
                   {stat_dirty_mask_o, stat_dirty_o, stat_lru_mask_o});
a_flush_tag: assert property (@(posedge clk_i) disable iff (reset_i)
  stat_we_o && !exp_fill |-> tag_we_o == exp_inv
    && (!exp_inv || (tag_way_mask_o == 4'(1 << exp_way) && !tag_valid_o && tag_o == '0)))
  else value_error("flush_tag", {exp_inv, 4'(1 << exp_way)}, {tag_we_o, tag_way_mask_o});

a_last_cmd: assert property (@(posedge clk_i) disable iff (reset_i)
  recover_o |-> last_cmd == exp_last)
  else value_error("dma_sequence", exp_last, last_cmd);
a_evict_count: assert property (@(posedge clk_i) disable iff (reset_i)
  recover_o |-> evict_seen == int'(exp_evict))
  else value_error("evict_count", exp_evict, evict_seen);
a_write_count: assert property (@(posedge clk_i) disable iff (reset_i)
  recover_o |-> meta_writes == 1)
  else value_error("meta_write_count", 1, meta_writes);
a_recover_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
  recover_o |=> !recover_o && done_o)
  else value_error("recover_done", 1, done_o);
a_done_hold: assert property (@(posedge clk_i) disable iff (reset_i)
  done_o && !ack_i |=> done_o)
  else value_error("done_hold", 1, done_o);
a_done_fall: assert property (@(posedge clk_i) disable iff (reset_i)
  done_o && ack_i |=> !done_o)
  else value_error("done_fall", 0, done_o);

`endif

// ==== testbench/miss_tb.sv ====
/*
  Testbench for the cache miss handler.
  Drives random miss and flush requests on the falling edge, answers DMA
  commands after a random delay and acknowledges done. The checks live
  in the included assertion header.
*/
module miss_tb;
  import miss_pkg::*;

  localparam int NUM_REQ = 60;

  logic                           clk_i = 1'b0;
  logic                           reset_i = 1'b1;
  logic                           miss_v_i = 1'b0;
  miss_op_e                       op_i = e_op_load;
  logic [ADDR_WIDTH-1:0]          addr_i = '0;
  logic [WAYS-1:0][TAG_WIDTH-1:0] tags_i = '0;
  logic [WAYS-1:0]                valid_i = '0;
  logic [WAYS-1:0]                dirty_i = '0;
  logic [LRU_WIDTH-1:0]           lru_bits_i = '0;
  logic [WAYS-1:0]                tag_hit_i = '0;
  logic                           dma_done_i = 1'b0;
  logic                           ack_i = 1'b0;
  dma_cmd_e                       dma_cmd_o;
  logic [ADDR_WIDTH-1:0]          dma_addr_o;
  logic [LG_WAYS-1:0]             dma_way_o;
  logic [LG_WAYS-1:0]             chosen_way_o;
  logic                           recover_o;
  logic                           done_o;
  logic                           stat_we_o;
  logic [LG_SETS-1:0]             stat_index_o;
  logic [WAYS-1:0]                stat_dirty_o;
  logic [WAYS-1:0]                stat_dirty_mask_o;
  logic [LRU_WIDTH-1:0]           stat_lru_o;
  logic [LRU_WIDTH-1:0]           stat_lru_mask_o;
  logic                           tag_we_o;
  logic [LG_SETS-1:0]             tag_index_o;
  logic [TAG_WIDTH-1:0]           tag_o;
  logic                           tag_valid_o;
  logic [WAYS-1:0]                tag_way_mask_o;

  // expectations for the request in flight.
  logic [31:0]          lfsr = 32'h45bb_a674;
  logic                 req_sent = 1'b0;
  logic                 exp_fill = 1'b0;
  logic                 exp_evict = 1'b0;
  logic                 exp_inv = 1'b0;
  logic                 exp_store = 1'b0;
  logic [LG_WAYS-1:0]   exp_way = '0;
  logic [TAG_WIDTH-1:0] exp_tag = '0;
  logic [LG_SETS-1:0]   exp_index = '0;
  dma_cmd_e             exp_last = e_dma_nop;
  dma_cmd_e             last_cmd = e_dma_nop;
  dma_cmd_e             pend_cmd = e_dma_nop;
  int                   evict_seen = 0;
  int                   meta_writes = 0;
  int                   dma_wait = 0;

  miss_unit dut0 (.*);

  always #5 clk_i = ~clk_i;

  // Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit taken.
  function automatic logic [31:0] get_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  `include "miss_tb_checks.svh"

  // metadata writes seen for the request in flight.
  always @(posedge clk_i) begin
    if (!reset_i && stat_we_o) begin
      meta_writes <= meta_writes + 1;
    end
  end

  // DMA engine model. A command is accepted after 0 to 3 idle cycles.
  always @(negedge clk_i) begin
    logic [31:0] r;
    if (dma_done_i) begin
      dma_done_i <= 1'b0;
      last_cmd   <= pend_cmd;
      if (pend_cmd == e_dma_send_evict_addr) begin
        evict_seen <= evict_seen + 1;
      end
    end else if (!reset_i && dma_cmd_o != e_dma_nop) begin
      if (dma_wait == 0) begin
        r = get_bits(2);
        dma_wait   <= int'(r[1:0]);
        pend_cmd   <= dma_cmd_o;
        dma_done_i <= 1'b1;
      end else begin
        dma_wait <= dma_wait - 1;
      end
    end
  end

  task automatic run_request(input int n);
    logic [31:0] r;
    logic [LG_WAYS-1:0] hit;
    miss_op_e op;
    op = miss_op_e'(3'(n % 5));
    r = get_bits(16);
    addr_i = r[15:0];
    for (int w = 0; w < WAYS; w++) begin
      r = get_bits(TAG_WIDTH);
      tags_i[w] = r[TAG_WIDTH-1:0];
    end
    r = get_bits(4);
    valid_i = r[3:0];
    r = get_bits(1);
    if (r[0]) begin
      valid_i = '1;
    end
    r = get_bits(4);
    dirty_i = r[3:0];
    r = get_bits(3);
    lru_bits_i = r[2:0];
    r = get_bits(2);
    hit = r[1:0];
    exp_fill  = (op == e_op_load) || (op == e_op_store);
    exp_store = (op == e_op_store);
    exp_inv   = (op == e_op_ainv) || (op == e_op_aflinv);
    tag_hit_i = '0;
    if (!exp_fill) begin
      valid_i[hit]   = 1'b1;
      tag_hit_i[hit] = 1'b1;
    end
    exp_way   = exp_fill ? ref_victim(valid_i, lru_bits_i) : hit;
    exp_evict = (op != e_op_ainv) && valid_i[exp_way] && dirty_i[exp_way];
    exp_tag   = addr_i[15:8];
    exp_index = addr_i[7:4];
    if (exp_fill) begin
      exp_last = e_dma_get_fill_data;
    end else begin
      exp_last = exp_evict ? e_dma_send_evict_data : e_dma_nop;
    end
    op_i        = op;
    last_cmd    = e_dma_nop;
    evict_seen  = 0;
    meta_writes = 0;
    req_sent    = 1'b1;
    miss_v_i    = 1'b1;
    @(negedge clk_i);
    miss_v_i = 1'b0;
    while (!done_o) begin
      @(negedge clk_i);
    end
    // hold ack back for a few cycles so that done must stay up.
    r = get_bits(2);
    repeat (int'(r[1:0])) @(negedge clk_i);
    ack_i = 1'b1;
    @(negedge clk_i);
    ack_i = 1'b0;
    @(negedge clk_i);
  endtask

  initial begin
    repeat (10) @(negedge clk_i);
    reset_i = 1'b0;
    repeat (3) @(negedge clk_i);
    for (int n = 0; n < NUM_REQ; n++) begin
      run_request(n);
    end
    repeat (4) @(negedge clk_i);
    $display("Result: PASSED");
    $finish;
  end

  // each request needs well under 40 cycles, even with slow DMA and ack.
  initial begin
    #((NUM_REQ * 40 + 20) * 10);
    $display("Watchdog expired before all requests completed.");
    $display("Result: FAILED");
    $fatal(1);
  end

endmodule

// ==== all.f ====
+incdir+testbench
hdl/miss_pkg.sv
hdl/miss_req_if.sv
hdl/miss_intake.sv
hdl/victim_select.sv
hdl/miss_fsm.sv
hdl/meta_write_gen.sv
hdl/miss_unit.sv
testbench/miss_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the miss handler testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module miss_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vmiss_tb > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Result: FAILED" sim.log; then
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
exit 0
